// File: spec_monitor.f
spec_pkg.sv
spec_ram.sv
bin_decode.sv
spec_rmw.sv
waterfall_store.sv
spec_monitor_top.sv
tb_clock_gen.sv
spec_monitor_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the spectrum store testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module spec_monitor_tb \
    -f spec_monitor.f -o spec_monitor_sim \
    && ./obj_dir/spec_monitor_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log && echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }

// File: spec_monitor_tb.sv
// ----------------------------------------------------------------------
// Testbench for the spectrum store top level
// Reference model of max hold, peak hold with decay and waterfall rows
// Display reads checked one cycle later against the model
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spec_monitor_tb;

    localparam int WF_DIV       = 4;                        // Lines per waterfall row
    localparam int DECAY_BITS   = 3;
    localparam int DECAY_FRAMES = 2 ** DECAY_BITS;
    localparam int NBINS        = 2 ** spec_pkg::BIN_BITS;
    localparam int NROWS        = 2 ** spec_pkg::ROW_BITS;
    localparam int MAX_CYCLES   = 20000;

    logic                  logfn_lineSync;
    logic                  global_rst;
    logic                  i_bin_valid;
    spec_pkg::bin_sample_t i_bin;
    logic                  i_frame_sync;
    logic                  i_line_done;
    spec_pkg::bin_t        i_rd_addr;
    spec_pkg::row_t        i_rd_row;
    spec_pkg::disp_rd_t    o_rd;

    // Model state
    spec_pkg::ampl_t spec_m [0:NBINS-1];
    spec_pkg::ampl_t peak_m [0:NBINS-1];
    spec_pkg::ampl_t wf_m   [0:NROWS-1][0:NBINS-1];
    spec_pkg::row_t  wr_line_m;
    int              line_div_m;
    int              decay_ctr_m;

    // Read compare pipeline
    logic               rd_valid;
    logic               cmp_valid;
    spec_pkg::disp_rd_t rd_exp;
    spec_pkg::disp_rd_t cmp_exp;
    int                 checks_done = 0;

    tb_clock_gen #(.PERIOD_NS(10), .RST_CYCLES(3)) u_tb_clock_gen (
        .o_clk(logfn_lineSync),
        .o_rst(global_rst)
    );

    spec_monitor_top #(
        .WF_LINE_DIV(WF_DIV),
        .DECAY_BITS (DECAY_BITS)
    ) u_spec_monitor_top (
        .logfn_lineSync(logfn_lineSync),
        .global_rst    (global_rst),
        .i_bin_valid   (i_bin_valid),
        .i_bin         (i_bin),
        .i_frame_sync  (i_frame_sync),
        .i_line_done   (i_line_done),
        .i_rd_addr     (i_rd_addr),
        .i_rd_row      (i_rd_row),
        .o_rd          (o_rd)
    );

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic spec_pkg::bin_t swap_halves(input spec_pkg::bin_t b);
        return b ^ spec_pkg::bin_t'(NBINS / 2);            // Top bit flipped
    endfunction

    function automatic void model_update(input spec_pkg::bin_t b, input spec_pkg::ampl_t a,
                                         input logic close);
        spec_pkg::bin_t  addr;
        spec_pkg::ampl_t old_s;
        spec_pkg::ampl_t old_p;
        spec_pkg::ampl_t new_s;
        addr  = swap_halves(b);
        old_s = spec_m[addr];
        old_p = peak_m[addr];
        if (close)
        begin
            new_s = '0;                                     // Cleared for the new frame
            if (old_s < old_p)
            begin
                peak_m[addr] = old_p - ((decay_ctr_m == 0) ? 8'd1 : 8'd0);
            end
            else
            begin
                peak_m[addr] = old_s;
            end
        end
        else
        begin
            new_s = (a > old_s) ? a : old_s;                // Max hold
        end
        spec_m[addr]          = new_s;
        wf_m[wr_line_m][addr] = new_s;                      // Waterfall follows spectrum
    endfunction

    function automatic spec_pkg::disp_rd_t expected_read(input spec_pkg::bin_t addr,
                                                         input spec_pkg::row_t row);
        spec_pkg::disp_rd_t exp_rd;
        spec_pkg::row_t     line;
        line        = wr_line_m - spec_pkg::row_t'(1) - row;   // Row 0 is newest complete
        exp_rd.spec = spec_m[addr];
        exp_rd.peak = peak_m[addr];
        exp_rd.wf   = wf_m[line][addr];
        return exp_rd;
    endfunction

    // ------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
            $display("SIMULATION FAILED");
            $fatal(1, "display read check");
        end
    endtask

    always @(posedge logfn_lineSync)
    begin
        cmp_valid <= rd_valid;                              // Data due one edge later
        cmp_exp   <= rd_exp;
    end

    always @(negedge logfn_lineSync)
    begin
        if (cmp_valid)
        begin
            check_value("o_rd.spec", o_rd.spec, cmp_exp.spec);
            check_value("o_rd.peak", o_rd.peak, cmp_exp.peak);
            check_value("o_rd.wf", o_rd.wf, cmp_exp.wf);
            checks_done++;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------
    task automatic send_bin(input int b, input int a);
        @(posedge logfn_lineSync);
        i_bin_valid <= 1'b1;
        i_bin.bin   <= spec_pkg::bin_t'(b);
        i_bin.ampl  <= spec_pkg::ampl_t'(a);
        model_update(spec_pkg::bin_t'(b), spec_pkg::ampl_t'(a), i_frame_sync);
        @(posedge logfn_lineSync);
        i_bin_valid <= 1'b0;
        repeat (2) @(posedge logfn_lineSync);               // 4-cycle strobe spacing
    endtask

    task automatic frame_start();
        @(posedge logfn_lineSync);
        i_frame_sync <= 1'b1;
        decay_ctr_m = (decay_ctr_m + DECAY_FRAMES - 1) % DECAY_FRAMES;
    endtask

    task automatic frame_end();
        @(posedge logfn_lineSync);
        i_frame_sync <= 1'b0;
    endtask

    task automatic line_done_pulse();
        @(posedge logfn_lineSync);
        i_line_done <= 1'b1;
        if (line_div_m == WF_DIV - 1)
        begin
            line_div_m = 0;
            wr_line_m  = wr_line_m + spec_pkg::row_t'(1);
        end
        else
        begin
            line_div_m++;
        end
        @(posedge logfn_lineSync);
        i_line_done <= 1'b0;
    endtask

    task automatic read_check(input int addr, input int row);
        @(posedge logfn_lineSync);
        i_rd_addr <= spec_pkg::bin_t'(addr);
        i_rd_row  <= spec_pkg::row_t'(row);
        rd_exp    <= expected_read(spec_pkg::bin_t'(addr), spec_pkg::row_t'(row));
        rd_valid  <= 1'b1;
        @(posedge logfn_lineSync);
        rd_valid  <= 1'b0;
    endtask

    task automatic read_all_bins(input int row);
        for (int a = 0; a < NBINS; a++)
        begin
            read_check(a, row);
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (global_rst !== 1'b0)
        begin
            @(posedge logfn_lineSync);
            n++;
            if (n > 20)
            begin
                $display("timeout: reset was never released");
                $display("SIMULATION FAILED");
                $fatal(1, "reset wait");
            end
        end
    endtask

    task automatic wait_compare_idle();
        int n;
        n = 0;
        while (rd_valid || cmp_valid)
        begin
            @(posedge logfn_lineSync);
            n++;
            if (n > 20)
            begin
                $display("timeout: display read compare did not drain");
                $display("SIMULATION FAILED");
                $fatal(1, "compare wait");
            end
        end
    endtask

    // Watchdog
    initial
    begin
        for (int cyc = 0; cyc < MAX_CYCLES; cyc++)
        begin
            @(posedge logfn_lineSync);
        end
        $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog");
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial
    begin
        int unsigned     seed_val;
        spec_pkg::ampl_t held;
        int              b;
        seed_val = $urandom(32'hfb0a);
        i_bin_valid  <= 1'b0;
        i_bin        <= '0;
        i_frame_sync <= 1'b0;
        i_line_done  <= 1'b0;
        i_rd_addr    <= '0;
        i_rd_row     <= '0;
        rd_valid     <= 1'b0;
        rd_exp       <= '0;
        for (int r = 0; r < NROWS; r++)
        begin
            for (int a = 0; a < NBINS; a++)
            begin
                wf_m[r][a] = '0;
            end
        end
        for (int a = 0; a < NBINS; a++)
        begin
            spec_m[a] = '0;
            peak_m[a] = '0;
        end
        wr_line_m   = '0;
        line_div_m  = 0;
        decay_ctr_m = 0;
        wait_reset_release();

        // Max hold of random amplitudes on one bin
        for (int i = 0; i < 6; i++)
        begin
            send_bin(3, 16 + ($urandom % 240));
        end
        read_check(swap_halves(3), 0);

        // Half swap, bin 20 lands at address 4, rest untouched
        send_bin(20, 8'ha5);
        read_all_bins(0);

        // Frame close moves max to peak
        held = spec_m[swap_halves(3)];
        frame_start();
        send_bin(3, $urandom % 256);
        frame_end();
        read_check(swap_halves(3), 0);
        send_bin(3, held / 2);                              // Weaker signal next frame
        frame_start();
        send_bin(3, $urandom % 256);
        frame_end();
        read_check(swap_halves(3), 0);

        // Peak decay over empty frames
        for (int f = 0; f < 20; f++)
        begin
            frame_start();
            send_bin(3, $urandom % 256);
            frame_end();
            read_check(swap_halves(3), 0);
        end

        // Waterfall rows shift every WF_DIV lines
        for (int line = 0; line < 12; line++)
        begin
            b = $urandom % NBINS;
            send_bin(b, $urandom % 256);
            send_bin($urandom % NBINS, $urandom % 256);
            line_done_pulse();
            for (int r = 0; r < 3; r++)
            begin
                read_check(swap_halves(spec_pkg::bin_t'(b)), r);
            end
        end
        for (int r = 0; r < NROWS; r++)
        begin
            read_all_bins(r);
        end

        wait_compare_idle();
        if (checks_done > 0)
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
        begin
            $display("SIMULATION FAILED");
            $fatal(1, "no display reads were compared");
        end
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// ----------------------------------------------------------------------
// Testbench clock and reset source for the spectrum store
// 10 ns line-sync clock, synchronous reset held for the first 3 edges
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;   // Free running
    end

    initial
    begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;                              // Released on a rising edge
    end

endmodule

`default_nettype wire

// File: spec_monitor_top.sv
// ---------------------------------------------------------------------
// Spectrum store top level, between the log stage and the display
// Decode, execute and result stages on the line-sync clock
// Bin strobe at T is readable from T+4, strobes 3 or more cycles apart
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spec_monitor_top #(
    parameter int WF_LINE_DIV = 4,  // FFT lines per waterfall row
    parameter int DECAY_BITS  = 3   // Peak decay every 8th frame
) (
    input  wire logic                  logfn_lineSync,
    input  wire logic                  global_rst,
    input  wire logic                  i_bin_valid,
    input  wire spec_pkg::bin_sample_t i_bin,
    input  wire logic                  i_frame_sync,
    input  wire logic                  i_line_done,
    input  wire spec_pkg::bin_t        i_rd_addr,
    input  wire spec_pkg::row_t        i_rd_row,
    output spec_pkg::disp_rd_t         o_rd
);

    // -----------------------------------------------------------------
    // Stage links
    // -----------------------------------------------------------------
    logic                 req_valid;
    spec_pkg::bin_req_t   req;
    spec_pkg::bin_t       rmw_addr;     // Engine read address
    spec_pkg::ampl_t      old_spec;
    spec_pkg::ampl_t      old_peak;
    spec_pkg::spec_wr_t   wr;

    bin_decode #(
        .DECAY_BITS(DECAY_BITS)
    ) u_bin_decode (
        .logfn_lineSync(logfn_lineSync),
        .global_rst    (global_rst),
        .i_bin_valid   (i_bin_valid),
        .i_bin         (i_bin),
        .i_frame_sync  (i_frame_sync),
        .o_req_valid   (req_valid),
        .o_req         (req)
    );

    spec_rmw u_spec_rmw (
        .logfn_lineSync(logfn_lineSync),
        .global_rst    (global_rst),
        .i_req_valid   (req_valid),
        .i_req         (req),
        .i_old_spec    (old_spec),
        .i_old_peak    (old_peak),
        .o_rd_addr     (rmw_addr),
        .o_wr          (wr)
    );

    waterfall_store #(
        .WF_LINE_DIV(WF_LINE_DIV)
    ) u_waterfall_store (
        .logfn_lineSync(logfn_lineSync),
        .global_rst    (global_rst),
        .i_wr          (wr),
        .i_line_done   (i_line_done),
        .i_rmw_addr    (rmw_addr),
        .o_old_spec    (old_spec),
        .o_old_peak    (old_peak),
        .i_rd_addr     (i_rd_addr),
        .i_rd_row      (i_rd_row),
        .o_rd          (o_rd)
    );

endmodule

`default_nettype wire

// File: waterfall_store.sv
// ---------------------------------------------------------------------
// Result stage: spectrum, peak and waterfall memories
// Update engine reads spectrum and peak through its own port, the
// display reads copies plus the waterfall, one cycle latency
// Waterfall row 0 is the newest completed line
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module waterfall_store #(
    parameter int WF_LINE_DIV = 4   // FFT lines per waterfall row
) (
    input  wire logic               logfn_lineSync,
    input  wire logic               global_rst,
    input  wire spec_pkg::spec_wr_t i_wr,
    input  wire logic               i_line_done,
    input  wire spec_pkg::bin_t     i_rmw_addr,
    output spec_pkg::ampl_t         o_old_spec,
    output spec_pkg::ampl_t         o_old_peak,
    input  wire spec_pkg::bin_t     i_rd_addr,
    input  wire spec_pkg::row_t     i_rd_row,
    output spec_pkg::disp_rd_t      o_rd
);

    localparam int AW    = spec_pkg::BIN_BITS;
    localparam int DW    = spec_pkg::AMPL_BITS;
    localparam int WF_AW = spec_pkg::ROW_BITS + spec_pkg::BIN_BITS;
    localparam int DIV_W = (WF_LINE_DIV > 1) ? $clog2(WF_LINE_DIV) : 1;

    logic [DIV_W-1:0] line_div;
    spec_pkg::row_t   wr_line;      // Row being filled
    spec_pkg::row_t   rd_line;
    spec_pkg::ampl_t  disp_spec;
    spec_pkg::ampl_t  disp_peak;
    spec_pkg::ampl_t  disp_wf;

    // -----------------------------------------------------------------
    // Waterfall line pointer
    // -----------------------------------------------------------------
    always_ff @(posedge logfn_lineSync)
    begin
        if (global_rst)
        begin
            line_div <= '0;
            wr_line  <= '0;
        end
        else if (i_line_done)
        begin
            if (line_div == DIV_W'(WF_LINE_DIV - 1))
            begin
                line_div <= '0;
                wr_line  <= wr_line + 1'b1;   // Next row, wraps around
            end
            else
            begin
                line_div <= line_div + 1'b1;
            end
        end
    end

    assign rd_line = wr_line - spec_pkg::row_t'(1) - i_rd_row;   // Newest complete row first

    // Engine read ports
    spec_ram #(.DATA_W(DW), .ADDR_W(AW)) u_spec_ram (
        .logfn_lineSync(logfn_lineSync), .i_wr_en(i_wr.spec_en), .i_wr_addr(i_wr.addr),
        .i_wr_data(i_wr.spec), .i_rd_addr(i_rmw_addr), .o_rd_data(o_old_spec));
    spec_ram #(.DATA_W(DW), .ADDR_W(AW)) u_peak_ram (
        .logfn_lineSync(logfn_lineSync), .i_wr_en(i_wr.peak_en), .i_wr_addr(i_wr.addr),
        .i_wr_data(i_wr.peak), .i_rd_addr(i_rmw_addr), .o_rd_data(o_old_peak));

    // Display copies
    spec_ram #(.DATA_W(DW), .ADDR_W(AW)) u_spec_disp (
        .logfn_lineSync(logfn_lineSync), .i_wr_en(i_wr.spec_en), .i_wr_addr(i_wr.addr),
        .i_wr_data(i_wr.spec), .i_rd_addr(i_rd_addr), .o_rd_data(disp_spec));
    spec_ram #(.DATA_W(DW), .ADDR_W(AW)) u_peak_disp (
        .logfn_lineSync(logfn_lineSync), .i_wr_en(i_wr.peak_en), .i_wr_addr(i_wr.addr),
        .i_wr_data(i_wr.peak), .i_rd_addr(i_rd_addr), .o_rd_data(disp_peak));

    // Waterfall, every spectrum write lands in the current row
    spec_ram #(.DATA_W(DW), .ADDR_W(WF_AW)) u_wf_ram (
        .logfn_lineSync(logfn_lineSync), .i_wr_en(i_wr.spec_en),
        .i_wr_addr({wr_line, i_wr.addr}), .i_wr_data(i_wr.spec),
        .i_rd_addr({rd_line, i_rd_addr}), .o_rd_data(disp_wf));

    assign o_rd = '{spec: disp_spec, peak: disp_peak, wf: disp_wf};

endmodule

`default_nettype wire

// File: spec_rmw.sv
// ---------------------------------------------------------------------
// Execute stage: read-modify-write of the spectrum and peak memories
// IDLE takes a request and presents its address, FETCH applies the
// max-hold, clear and peak rules, WRITE pulses the write enables
// Requests outside IDLE are dropped
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spec_rmw (
    input  wire logic               logfn_lineSync,
    input  wire logic               global_rst,
    input  wire logic               i_req_valid,
    input  wire spec_pkg::bin_req_t i_req,
    input  wire spec_pkg::ampl_t    i_old_spec,
    input  wire spec_pkg::ampl_t    i_old_peak,
    output spec_pkg::bin_t          o_rd_addr,
    output spec_pkg::spec_wr_t      o_wr
);

    spec_pkg::rmw_state_t state;
    spec_pkg::bin_req_t   req_q;        // Captured request
    spec_pkg::ampl_t      spec_max;
    spec_pkg::ampl_t      peak_next;
    spec_pkg::ampl_t      wr_spec;
    spec_pkg::ampl_t      wr_peak;
    logic                 wr_spec_en;
    logic                 wr_peak_en;

    // Address straight from the request in IDLE so old data is back in FETCH
    assign o_rd_addr = (state == spec_pkg::RMW_IDLE) ? i_req.addr : req_q.addr;

    // Max hold within a frame
    assign spec_max = (i_old_spec < req_q.ampl) ? req_q.ampl : i_old_spec;

    // Peak follows the held max, or decays while the max is below it
    assign peak_next = (i_old_spec < i_old_peak) ?
                       (i_old_peak - spec_pkg::ampl_t'(req_q.decay)) : i_old_spec;

    // -----------------------------------------------------------------
    // FSM and write enables
    // -----------------------------------------------------------------
    always_ff @(posedge logfn_lineSync)
    begin
        if (global_rst)
        begin
            state      <= spec_pkg::RMW_IDLE;
            wr_spec_en <= 1'b0;
            wr_peak_en <= 1'b0;
        end
        else
        begin
            case (state)
                spec_pkg::RMW_IDLE:
                begin
                    if (i_req_valid)
                    begin
                        state <= spec_pkg::RMW_FETCH;
                    end
                end
                spec_pkg::RMW_FETCH:
                begin
                    state      <= spec_pkg::RMW_WRITE;
                    wr_spec_en <= 1'b1;
                    wr_peak_en <= req_q.close;    // Peak only taken at frame close
                end
                spec_pkg::RMW_WRITE:
                begin
                    state      <= spec_pkg::RMW_IDLE;
                    wr_spec_en <= 1'b0;
                    wr_peak_en <= 1'b0;
                end
                default:
                begin
                    state <= spec_pkg::RMW_IDLE;
                end
            endcase
        end
    end

    // Payload
    always_ff @(posedge logfn_lineSync)
    begin
        if ((state == spec_pkg::RMW_IDLE) && i_req_valid)
        begin
            req_q <= i_req;
        end
        if (state == spec_pkg::RMW_FETCH)
        begin
            wr_spec <= req_q.close ? '0 : spec_max;   // Clear for the new frame
            wr_peak <= peak_next;
        end
    end

    assign o_wr = '{addr: req_q.addr, spec: wr_spec, peak: wr_peak,
                    spec_en: wr_spec_en, peak_en: wr_peak_en};

endmodule

`default_nettype wire

// File: bin_decode.sv
// ---------------------------------------------------------------------
// Decode stage: registers each bin strobe into an update request
// Swaps the spectrum halves and tags frame close and peak decay
// One cycle from strobe to request
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bin_decode #(
    parameter int DECAY_BITS = 3    // Decay once per 2**DECAY_BITS frames
) (
    input  wire logic                 logfn_lineSync,
    input  wire logic                 global_rst,
    input  wire logic                 i_bin_valid,
    input  wire spec_pkg::bin_sample_t i_bin,
    input  wire logic                 i_frame_sync,
    output logic                      o_req_valid,
    output spec_pkg::bin_req_t        o_req
);

    localparam int MSB = spec_pkg::BIN_BITS - 1;

    logic                  sync_q;      // Frame sync, previous cycle
    logic                  sync_rise;
    logic [DECAY_BITS-1:0] decay_ctr;

    assign sync_rise = i_frame_sync & ~sync_q;

    // -----------------------------------------------------------------
    // Control: strobe pipeline, edge detect, decay counter
    // -----------------------------------------------------------------
    always_ff @(posedge logfn_lineSync)
    begin
        if (global_rst)
        begin
            o_req_valid <= 1'b0;
            sync_q      <= 1'b0;
            decay_ctr   <= '0;
        end
        else
        begin
            o_req_valid <= i_bin_valid;     // One-cycle pulse
            sync_q      <= i_frame_sync;
            if (sync_rise)
            begin
                decay_ctr <= decay_ctr - 1'b1;   // Counts down once per frame
            end
        end
    end

    // -----------------------------------------------------------------
    // Request payload, held between strobes
    // -----------------------------------------------------------------
    always_ff @(posedge logfn_lineSync)
    begin
        if (i_bin_valid)
        begin
            // Top bit inverted puts DC in the middle of the display
            o_req.addr  <= {~i_bin.bin[MSB], i_bin.bin[MSB-1:0]};
            o_req.ampl  <= i_bin.ampl;
            o_req.close <= i_frame_sync;           // Update lands in frame start
            o_req.decay <= (decay_ctr == '0);      // Decay frame
        end
    end

endmodule

`default_nettype wire

// File: spec_ram.sv
// ---------------------------------------------------------------------
// Simple dual-port RAM, one write port and one registered read port
// Contents start at zero like block RAM after configuration
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module spec_ram #(
    parameter int DATA_W = 8,
    parameter int ADDR_W = 5
) (
    input  wire logic              logfn_lineSync,
    input  wire logic              i_wr_en,
    input  wire logic [ADDR_W-1:0] i_wr_addr,
    input  wire logic [DATA_W-1:0] i_wr_data,
    input  wire logic [ADDR_W-1:0] i_rd_addr,
    output logic      [DATA_W-1:0] o_rd_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [DATA_W-1:0] mem [0:DEPTH-1] = '{default: '0};   // Zero at start

    always_ff @(posedge logfn_lineSync)
    begin
        if (i_wr_en)
        begin
            mem[i_wr_addr] <= i_wr_data;
        end
        o_rd_data <= mem[i_rd_addr];   // Old data on a same-address collision
    end

endmodule

`default_nettype wire

// File: spec_pkg.sv
// ---------------------------------------------------------------------
// Shared widths, types and structs of the spectrum store
// Referenced by scoped names from every RTL module and the testbench
// Sized down to 32 bins and 8 waterfall rows for simulation
// ---------------------------------------------------------------------
`default_nettype none

package spec_pkg;

    localparam int BIN_BITS  = 5;   // 32 FFT bins
    localparam int ROW_BITS  = 3;   // 8 waterfall rows
    localparam int AMPL_BITS = 8;   // Log amplitude, about 2.7 dB per step

    typedef logic [AMPL_BITS-1:0] ampl_t;   // Log amplitude
    typedef logic [BIN_BITS-1:0]  bin_t;    // Bin index or memory address
    typedef logic [ROW_BITS-1:0]  row_t;    // Waterfall row

    // One log-magnitude sample from the FFT path
    typedef struct packed {
        bin_t  bin;
        ampl_t ampl;
    } bin_sample_t;

    // Decode to execute
    typedef struct packed {
        bin_t  addr;    // Half-swapped address
        ampl_t ampl;
        logic  close;   // Frame close, sampled from frame sync
        logic  decay;   // Peak decays by one step
    } bin_req_t;

    // Execute to result
    typedef struct packed {
        bin_t  addr;
        ampl_t spec;     // New max-hold value
        ampl_t peak;     // New peak-hold value
        logic  spec_en;
        logic  peak_en;
    } spec_wr_t;

    // Values returned to the display
    typedef struct packed {
        ampl_t spec;
        ampl_t peak;
        ampl_t wf;
    } disp_rd_t;

    typedef enum logic [1:0] {
        RMW_IDLE,
        RMW_FETCH,
        RMW_WRITE
    } rmw_state_t;

endpackage

`default_nettype wire
